// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_wts_mixer
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

SOURCES = $(shell cat $(FILELIST))
SIM     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/wts_channel_volume.sv ====
// Volume scaling and left/right routing of the channel in flight
`timescale 1ns/10ps

module wts_channel_volume (
	input  logic clk,
	input  logic nreset,
	input  wts_pkg::slot_t slot,
	input  logic sounding,
	input  wts_pkg::sample_t ram_q,
	input  wts_pkg::volume_t reg_volume [wts_pkg::num_channels],
	input  wts_pkg::enable_t reg_enable [wts_pkg::num_channels],
	output wts_pkg::sample_t left_part,
	output wts_pkg::sample_t right_part,
	output wts_pkg::slot_t part_slot
);
	import wts_pkg::*;

	slot_t slot_d;
	logic sounding_d;
	logic [ram_addr_bits-wave_len_bits-1:0] ch;
	volume_t vol;
	enable_t en;
	logic signed [12:0] product;
	sample_t scaled;

	// Slot and gate line up with the RAM output
	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot_d <= slot_cpu;
			sounding_d <= 1'b0;
		end else begin
			slot_d <= slot;
			sounding_d <= sounding;
		end
	end

	always_comb begin
		ch = (slot_d == slot_cpu) ? '0 : slot_d;
		vol = reg_volume[ch];
		en = reg_enable[ch];
		product = ram_q * $signed({1'b0, vol});
		scaled = sample_t'(product >>> 4);
	end

	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_part <= '0;
			right_part <= '0;
			part_slot <= slot_ch_f;
		end else begin
			left_part <= (sounding_d && en[1]) ? scaled : '0;
			right_part <= (sounding_d && en[0]) ? scaled : '0;
			part_slot <= slot_d;
		end
	end

	// Tags leave in frame order
	assert property (@(posedge clk) disable iff (!nreset)
		part_slot != slot_cpu |=> part_slot == slot_t'($past(part_slot) + 3'd1))
		else $error("wts_channel_volume: slot tag out of order");

	assert property (@(posedge clk) disable iff (!nreset)
		part_slot == slot_cpu |=> part_slot == slot_ch_a)
		else $error("wts_channel_volume: frame did not wrap to channel A");

endmodule

// ==== rtl/wts_cpu_access.sv ====
// CPU request latch for the wave RAM with done and read data strobes
`timescale 1ns/10ps

module wts_cpu_access (
	input  logic clk,
	input  logic nreset,
	input  wts_pkg::slot_t slot,
	input  logic [wts_pkg::ram_addr_bits-wts_pkg::wave_len_bits-1:0] sram_id,
	input  logic [wts_pkg::wave_len_bits-1:0] sram_a,
	input  wts_pkg::sample_t sram_d,
	input  logic sram_oe,
	input  logic sram_we,
	output logic [wts_pkg::ram_addr_bits-1:0] cpu_addr,
	output wts_pkg::sample_t cpu_wdata,
	output logic cpu_we,
	input  wts_pkg::sample_t ram_q,
	output wts_pkg::sample_t sram_q,
	output logic sram_q_en,
	output logic sram_done
);
	import wts_pkg::*;

	logic pend_rd;
	logic pend_wr;
	logic [ram_addr_bits-1:0] pend_addr;
	sample_t pend_data;
	sample_t q_hold;
	logic service;

	// A pending request is carried out in the CPU slot
	assign service = (slot == slot_cpu) && (pend_rd || pend_wr);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			pend_rd <= 1'b0;
			pend_wr <= 1'b0;
		end else if (sram_oe || sram_we) begin
			pend_rd <= sram_oe;
			pend_wr <= sram_we;
		end else if (service) begin
			pend_rd <= 1'b0;
			pend_wr <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (sram_oe || sram_we) begin
			pend_addr <= {sram_id, sram_a};
			pend_data <= sram_d;
		end
	end

	// ----------------------------------------
	// Completion one cycle after the CPU slot

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sram_done <= 1'b0;
			sram_q_en <= 1'b0;
		end else begin
			sram_done <= service;
			sram_q_en <= service && pend_rd;
		end
	end

	// Read data stays visible until the next read
	always_ff @(posedge clk) begin
		if (sram_q_en) begin
			q_hold <= ram_q;
		end
	end

	assign sram_q = sram_q_en ? ram_q : q_hold;
	assign cpu_addr = pend_addr;
	assign cpu_wdata = pend_data;
	assign cpu_we = pend_wr && (slot == slot_cpu);

	// The master waits for sram_done before its next request
	assert property (@(posedge clk) disable iff (!nreset)
		(sram_oe || sram_we) |-> !(pend_rd || pend_wr))
		else $error("wts_cpu_access: new request while one is pending");

endmodule

// ==== rtl/wts_mixer.sv ====
// Wave table mixer top level with six channels sharing one wave RAM
`timescale 1ns/10ps

module wts_mixer (
	input  logic clk,
	input  logic nreset,
	input  logic key_on [wts_pkg::num_channels],
	input  logic key_off [wts_pkg::num_channels],
	input  wts_pkg::volume_t reg_volume [wts_pkg::num_channels],
	input  wts_pkg::enable_t reg_enable [wts_pkg::num_channels],
	input  wts_pkg::freq_t reg_frequency_count [wts_pkg::num_channels],
	input  logic [wts_pkg::ram_addr_bits-wts_pkg::wave_len_bits-1:0] sram_id,
	input  logic [wts_pkg::wave_len_bits-1:0] sram_a,
	input  wts_pkg::sample_t sram_d,
	input  logic sram_oe,
	input  logic sram_we,
	output wts_pkg::sample_t sram_q,
	output logic sram_q_en,
	output logic sram_done,
	output wts_pkg::out_t left_out,
	output wts_pkg::out_t right_out
);
	import wts_pkg::*;

	slot_t slot;
	logic [ram_addr_bits-1:0] play_addr;
	logic sounding;
	logic [ram_addr_bits-1:0] cpu_addr;
	sample_t cpu_wdata;
	logic cpu_we;
	sample_t ram_q;
	sample_t left_part;
	sample_t right_part;
	slot_t part_slot;

	// ----------------------------------------
	// Slot timing and wave addresses

	wts_wave_sequencer u_wave_sequencer (
		.clk                 (clk),
		.nreset              (nreset),
		.key_on              (key_on),
		.key_off             (key_off),
		.reg_frequency_count (reg_frequency_count),
		.slot                (slot),
		.play_addr           (play_addr),
		.sounding            (sounding)
	);

	wts_cpu_access u_cpu_access (
		.clk       (clk),
		.nreset    (nreset),
		.slot      (slot),
		.sram_id   (sram_id),
		.sram_a    (sram_a),
		.sram_d    (sram_d),
		.sram_oe   (sram_oe),
		.sram_we   (sram_we),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_we    (cpu_we),
		.ram_q     (ram_q),
		.sram_q    (sram_q),
		.sram_q_en (sram_q_en),
		.sram_done (sram_done)
	);

	wts_wave_ram u_wave_ram (
		.clk       (clk),
		.slot      (slot),
		.play_addr (play_addr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_we    (cpu_we),
		.ram_q     (ram_q)
	);

	// ----------------------------------------
	// Volume, panning and frame sum

	wts_channel_volume u_channel_volume (
		.clk        (clk),
		.nreset     (nreset),
		.slot       (slot),
		.sounding   (sounding),
		.ram_q      (ram_q),
		.reg_volume (reg_volume),
		.reg_enable (reg_enable),
		.left_part  (left_part),
		.right_part (right_part),
		.part_slot  (part_slot)
	);

	wts_stereo_accum u_stereo_accum (
		.clk        (clk),
		.nreset     (nreset),
		.left_part  (left_part),
		.right_part (right_part),
		.part_slot  (part_slot),
		.left_out   (left_out),
		.right_out  (right_out)
	);

endmodule

// ==== rtl/wts_pkg.sv ====
// Widths, sample and register types, slot enum and frame constants
// shared by the wave table mixer
package wts_pkg;

	// ----------------------------------------
	// Sizes

	localparam int num_channels = 6;

	// 32 samples per wave
	localparam int wave_len_bits = 5;

	// Upper bits pick the channel and lower bits the sample
	localparam int ram_addr_bits = 8;

	// ----------------------------------------
	// Data and register types

	typedef logic signed [7:0] sample_t;
	typedef logic [3:0] volume_t;

	// Bit 1 enables the left side and bit 0 the right side
	typedef logic [1:0] enable_t;

	typedef logic [11:0] freq_t;
	typedef logic [11:0] out_t;

	// Six playback slots and one slot reserved for the CPU
	typedef enum logic [2:0] {
		slot_ch_a,
		slot_ch_b,
		slot_ch_c,
		slot_ch_d,
		slot_ch_e,
		slot_ch_f,
		slot_cpu
	} slot_t;

	localparam int frame_len = 7;

	// Offset-binary silence
	localparam out_t out_midpoint = 12'h800;

endpackage

// ==== rtl/wts_stereo_accum.sv ====
// Frame accumulator for left and right contributions,
// with offset-binary output registers
`timescale 1ns/10ps

module wts_stereo_accum (
	input  logic clk,
	input  logic nreset,
	input  wts_pkg::sample_t left_part,
	input  wts_pkg::sample_t right_part,
	input  wts_pkg::slot_t part_slot,
	output wts_pkg::out_t left_out,
	output wts_pkg::out_t right_out
);
	import wts_pkg::*;

	out_t sum_left;
	out_t sum_right;
	out_t left_ext;
	out_t right_ext;

	// ----------------------------------------
	// Sign extension to the sum width

	assign left_ext = {{4{left_part[7]}}, left_part};
	assign right_ext = {{4{right_part[7]}}, right_part};

	// ----------------------------------------
	// Running sums

	always_ff @(posedge clk) begin
		if (!nreset) begin
			sum_left <= '0;
			sum_right <= '0;
		end else if (part_slot == slot_cpu) begin
			// The CPU tag closes the frame and starts a new one
			sum_left <= '0;
			sum_right <= '0;
		end else begin
			sum_left <= sum_left + left_ext;
			sum_right <= sum_right + right_ext;
		end
	end

	// ----------------------------------------
	// Output registers

	// Inverting the sign bit turns two's complement into offset binary
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_out <= out_midpoint;
			right_out <= out_midpoint;
		end else if (part_slot == slot_cpu) begin
			left_out <= {~sum_left[11], sum_left[10:0]};
			right_out <= {~sum_right[11], sum_right[10:0]};
		end
	end

	// The CPU slot never carries a channel contribution
	assert property (@(posedge clk) disable iff (!nreset)
		part_slot == slot_cpu |-> (left_part == '0 && right_part == '0))
		else $error("wts_stereo_accum: contribution tagged with the CPU slot");

endmodule

// ==== rtl/wts_wave_ram.sv ====
// Single-port 256 x 8 wave RAM shared by playback and the CPU slot
`timescale 1ns/10ps

module wts_wave_ram (
	input  logic clk,
	input  wts_pkg::slot_t slot,
	input  logic [wts_pkg::ram_addr_bits-1:0] play_addr,
	input  logic [wts_pkg::ram_addr_bits-1:0] cpu_addr,
	input  wts_pkg::sample_t cpu_wdata,
	input  logic cpu_we,
	output wts_pkg::sample_t ram_q
);
	import wts_pkg::*;

	sample_t mem [2**ram_addr_bits];
	logic [ram_addr_bits-1:0] addr;

	// The CPU owns the port only in its own slot
	assign addr = (slot == slot_cpu) ? cpu_addr : play_addr;

	// Read before write on the same address
	always_ff @(posedge clk) begin
		if (cpu_we) begin
			mem[addr] <= cpu_wdata;
		end
		ram_q <= mem[addr];
	end

endmodule

// ==== rtl/wts_wave_sequencer.sv ====
// Frame slot counter with per-channel frequency counters,
// wave indexes and key state
`timescale 1ns/10ps

module wts_wave_sequencer (
	input  logic clk,
	input  logic nreset,
	input  logic key_on [wts_pkg::num_channels],
	input  logic key_off [wts_pkg::num_channels],
	input  wts_pkg::freq_t reg_frequency_count [wts_pkg::num_channels],
	output wts_pkg::slot_t slot,
	output logic [wts_pkg::ram_addr_bits-1:0] play_addr,
	output logic sounding
);
	import wts_pkg::*;

	logic [wave_len_bits-1:0] wave_index [num_channels];
	freq_t freq_cnt [num_channels];
	logic [num_channels-1:0] playing;
	logic [ram_addr_bits-wave_len_bits-1:0] cur_ch;

	// ----------------------------------------
	// Slot counter

	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot <= slot_ch_a;
		end else if (slot == slot_cpu) begin
			slot <= slot_ch_a;
		end else begin
			slot <= slot_t'(slot + 3'd1);
		end
	end

	// The CPU slot parks on channel A so the index stays in range
	always_comb begin
		cur_ch = (slot == slot_cpu) ? '0 : slot;
	end

	// ----------------------------------------
	// Per-channel wave position

	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < num_channels; i++) begin
				wave_index[i] <= '0;
				freq_cnt[i] <= '0;
			end
			playing <= '0;
		end else begin
			for (int i = 0; i < num_channels; i++) begin
				if (key_on[i]) begin
					wave_index[i] <= '0;
					freq_cnt[i] <= reg_frequency_count[i];
					playing[i] <= 1'b1;
				end else if (key_off[i]) begin
					playing[i] <= 1'b0;
				end else if (playing[i] && slot != slot_cpu && cur_ch == i) begin
					// One count per frame, taken in the channel's own slot
					if (freq_cnt[i] == '0) begin
						freq_cnt[i] <= reg_frequency_count[i];
						wave_index[i] <= wave_index[i] + 1'b1;
					end else begin
						freq_cnt[i] <= freq_cnt[i] - 1'b1;
					end
				end
			end
		end
	end

	// ----------------------------------------
	// Address and gate of the channel in this slot

	always_comb begin
		play_addr = {cur_ch, wave_index[cur_ch]};
		sounding = playing[cur_ch] && (slot != slot_cpu);
	end

endmodule

// ==== sim/tb_wts_mixer.sv ====
// Testbench for the wave table mixer with clock, reset, case file reader
// and the CPU, register and key stimulus
`timescale 1ns/10ps

module tb_wts_mixer;
	import wts_pkg::*;

	localparam int settle_frames = 4;
	localparam int watch_frames = 80;
	localparam int wait_limit = 64;

	logic clk;
	logic nreset;
	logic key_on [num_channels];
	logic key_off [num_channels];
	volume_t reg_volume [num_channels];
	enable_t reg_enable [num_channels];
	freq_t reg_frequency_count [num_channels];
	logic [2:0] sram_id;
	logic [4:0] sram_a;
	sample_t sram_d;
	logic sram_oe;
	logic sram_we;
	sample_t sram_q;
	logic sram_q_en;
	logic sram_done;
	out_t left_out;
	out_t right_out;

	int read_count;
	sample_t exp_q;
	logic check_stb;
	out_t exp_left;
	out_t exp_right;
	logic watch_en;
	out_t watch_p;
	out_t watch_q;
	int error_count;
	int tb_errors;

	wts_mixer i_wts_mixer (.*);

	wts_checker u_wts_checker (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Every operation starts and ends 1 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic settle();
		repeat (settle_frames * frame_len) @(posedge clk);
		#1;
	endtask

	task automatic cpu_request(input bit is_read, input int ch, input int idx, input int val);
		int n;
		sram_id = ch[2:0];
		sram_a = idx[4:0];
		sram_d = val[7:0];
		sram_oe = is_read;
		sram_we = !is_read;
		next_cycle();
		sram_oe = 1'b0;
		sram_we = 1'b0;
		for (n = 0; n < wait_limit; n++) begin
			@(negedge clk);
			if (is_read ? sram_q_en : sram_done) break;
		end
		if (n == wait_limit) begin
			$display("No completion came for the CPU access to channel %0d sample %0d", ch, idx);
			tb_errors++;
		end
		next_cycle();
	endtask

	task automatic set_channel(input int ch, input int vol, input int en, input int freq);
		reg_volume[ch] = vol[3:0];
		reg_enable[ch] = en[1:0];
		reg_frequency_count[ch] = freq[11:0];
		next_cycle();
	endtask

	task automatic pulse_key(input int ch, input bit on);
		key_on[ch] = on;
		key_off[ch] = !on;
		next_cycle();
		key_on[ch] = 1'b0;
		key_off[ch] = 1'b0;
	endtask

	task automatic check_outputs(input int left, input int right);
		settle();
		exp_left = left[11:0];
		exp_right = right[11:0];
		check_stb = 1'b1;
		next_cycle();
		check_stb = 1'b0;
	endtask

	task automatic watch_wave(input int p, input int q);
		settle();
		watch_p = p[11:0];
		watch_q = q[11:0];
		watch_en = 1'b1;
		repeat (watch_frames * frame_len) @(posedge clk);
		#1;
		watch_en = 1'b0;
		next_cycle();
	endtask

	initial begin
		int fd;
		int code;
		int ch;
		int f1;
		int f2;
		int f3;
		int f4;
		string op;
		nreset = 1'b0;
		sram_id = '0;
		sram_a = '0;
		sram_d = '0;
		sram_oe = 1'b0;
		sram_we = 1'b0;
		for (int i = 0; i < num_channels; i++) begin
			key_on[i] = 1'b0;
			key_off[i] = 1'b0;
			reg_volume[i] = '0;
			reg_enable[i] = '0;
			reg_frequency_count[i] = '0;
		end
		read_count = 0;
		exp_q = '0;
		check_stb = 1'b0;
		exp_left = '0;
		exp_right = '0;
		watch_en = 1'b0;
		watch_p = '0;
		watch_q = '0;
		tb_errors = 0;
		repeat (10) @(posedge clk);
		#1;
		nreset = 1'b1;

		// ----------------------------------------
		// One operation per line of the case file
		fd = $fopen("sim/wts_cases.txt", "r");
		if (fd == 0) begin
			$display("The case file sim/wts_cases.txt could not be opened");
			tb_errors++;
		end
		while (fd != 0 && tb_errors == 0) begin
			code = $fscanf(fd, "%s", op);
			if (code != 1) break;
			case (op)
				"#": begin
					ch = 0;
					while (ch != 10 && ch != -1) ch = $fgetc(fd);
				end
				"w": begin
					code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
					for (int idx = f2; idx <= f3; idx++) cpu_request(1'b0, f1, idx, f4);
				end
				"r": begin
					code = $fscanf(fd, "%h %h %h", f1, f2, f3);
					exp_q = f3[7:0];
					read_count++;
					cpu_request(1'b1, f1, f2, 0);
				end
				"v": begin
					code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
					set_channel(f1, f2, f3, f4);
				end
				"on": begin
					code = $fscanf(fd, "%h", f1);
					pulse_key(f1, 1'b1);
				end
				"off": begin
					code = $fscanf(fd, "%h", f1);
					pulse_key(f1, 1'b0);
				end
				"c": begin
					code = $fscanf(fd, "%h %h", f1, f2);
					check_outputs(f1, f2);
				end
				"a": begin
					code = $fscanf(fd, "%h %h", f1, f2);
					watch_wave(f1, f2);
				end
				default: begin
					$display("The case file holds an unknown operation %s", op);
					tb_errors++;
				end
			endcase
		end
		if (fd != 0) $fclose(fd);

		next_cycle();
		$display("Checker errors: %0d, testbench errors: %0d", error_count, tb_errors);
		if (error_count == 0 && tb_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== sim/wts_cases.txt ====
# Fields in hex: w ch first last value | r ch sample expected | v ch vol en freq
# on ch | off ch | c left right | a left_p left_q (left_out alternates for 80 frames)
c 800 800
w 0 00 00 11
w 2 07 07 a5
w 5 1f 1f 7f
w 3 10 10 c3
r 0 00 11
r 2 07 a5
r 5 1f 7f
r 3 10 c3
w 0 00 1f 40
v 0 8 2 003
on 0
r 0 1f 40
c 820 800
w 1 00 1f d0
v 1 f 3 005
on 1
w 2 00 1f 7f
v 2 4 1 000
on 2
w 3 00 1f 80
v 3 f 2 7ff
on 3
w 4 00 1f fd
v 4 5 3 002
on 4
c 77a 7f1
off 0
off 1
off 2
off 3
off 4
c 800 800
w 5 00 0f 20
w 5 10 1f e0
v 5 f 2 001
on 5
a 81e 7e2

// ==== sim/wts_checker.sv ====
// Output checker for the wave table mixer covering read data, frame outputs
// and the two-value watch window
`timescale 1ns/10ps

module wts_checker (
	input  logic clk,
	input  logic nreset,
	input  wts_pkg::sample_t sram_q,
	input  logic sram_q_en,
	input  logic sram_done,
	input  wts_pkg::out_t left_out,
	input  wts_pkg::out_t right_out,
	input  int read_count,
	input  wts_pkg::sample_t exp_q,
	input  logic check_stb,
	input  wts_pkg::out_t exp_left,
	input  wts_pkg::out_t exp_right,
	input  logic watch_en,
	input  wts_pkg::out_t watch_p,
	input  wts_pkg::out_t watch_q,
	output int error_count
);
	import wts_pkg::*;

	int errors = 0;
	int q_en_count = 0;
	logic seen_p = 1'b0;
	logic seen_q = 1'b0;
	logic watch_d = 1'b0;

	assign error_count = errors;

	task automatic report_value(input string name, input int expected, input int actual);
		$display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
		errors++;
	endtask

	// Outputs are registered on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		if (nreset) begin
			// ----------------------------------------
			// One read data pulse per read request
			if (sram_q_en) begin
				if (!sram_done) begin
					$display("An sram_q_en pulse came at %0t without sram_done", $time);
					errors++;
				end
				if (q_en_count >= read_count) begin
					$display("An sram_q_en pulse came at %0t with no read outstanding", $time);
					errors++;
				end else if (sram_q !== exp_q) begin
					report_value("sram_q", exp_q, sram_q);
				end
				q_en_count++;
			end

			if (check_stb) begin
				if (left_out !== exp_left) report_value("left_out", exp_left, left_out);
				if (right_out !== exp_right) report_value("right_out", exp_right, right_out);
			end

			// ----------------------------------------
			// Every frame of the two-value wave shows one of them and both show up
			if (watch_en) begin
				if (left_out === watch_p) begin
					seen_p = 1'b1;
				end else if (left_out === watch_q) begin
					seen_q = 1'b1;
				end else begin
					$display("FAIL %0t left_out expected %0h or %0h actual %0h",
						$time, watch_p, watch_q, left_out);
					errors++;
				end
			end else if (watch_d) begin
				if (!(seen_p && seen_q)) begin
					$display("left_out did not show both wave values within the watch window");
					errors++;
				end
				seen_p = 1'b0;
				seen_q = 1'b0;
			end
			watch_d = watch_en;
		end
	end

endmodule

// ==== verilog.f ====
rtl/wts_pkg.sv
rtl/wts_wave_sequencer.sv
rtl/wts_cpu_access.sv
rtl/wts_wave_ram.sv
rtl/wts_channel_volume.sv
rtl/wts_stereo_accum.sv
rtl/wts_mixer.sv
sim/wts_checker.sv
sim/tb_wts_mixer.sv
